// File: src/zx_pkg.sv
package zx_pkg;

  // cpu clock select, value 3 behaves as 14 MHz
  typedef enum logic [1:0] {
    TURBO_3M5 = 2'd0,
    TURBO_7M  = 2'd1,
    TURBO_14M = 2'd2
  } turbo_t;

  typedef enum logic [1:0] {
    PORT_NONE    = 2'd0,
    PORT_FE      = 2'd1,
    PORT_SYSCONF = 2'd2,
    PORT_INTMASK = 2'd3
  } port_sel_t;

  typedef enum logic {
    INT_IDLE   = 1'b0,
    INT_ACTIVE = 1'b1
  } int_state_t;

  // port addresses
  localparam logic [7:0]  PORT_FE_LOW  = 8'hFE;    // low byte only
  localparam logic [15:0] SYSCONF_ADDR = 16'h20AF;
  localparam logic [15:0] INTMASK_ADDR = 16'h2AAF;

  // sysconf: [1:0] turbo, [5] tape sound
  localparam logic [2:0] SYSCONF_TAPE_SOUND_BIT = 3'd5;

  // #FE bits
  localparam logic [2:0] FE_BEEPER_BIT = 3'd4;
  localparam logic [2:0] FE_TAPE_BIT   = 3'd6;

  localparam logic [7:0] IM2_FRAME_VECT = 8'hFF;

  // register values after reset
  localparam logic [7:0] SYSCONF_RESET = 8'h00;
  localparam logic [7:0] INTMASK_RESET = 8'h01;  // frame int on

endpackage

// File: src/resetter.sv
`timescale 1ns/1ps

module resetter #(
  parameter int RST_STRETCH = 8
) (
  input  logic fclk,
  input  logic rst,
  output logic core_rst
);

  localparam int CW = $clog2(RST_STRETCH + 1);

  logic [CW-1:0] cnt;

  always_ff @(posedge fclk) begin
    if (rst) begin
      cnt      <= CW'(RST_STRETCH);
      core_rst <= 1'b1;
    end else if (cnt != '0) begin
      cnt      <= cnt - 1'b1;  // hold while draining
      core_rst <= 1'b1;
    end else begin
      core_rst <= 1'b0;
    end
  end

endmodule

// File: src/zclock.sv
`timescale 1ns/1ps

module zclock (
  input  logic           fclk,
  input  logic           core_rst,
  input  zx_pkg::turbo_t turbo,
  output logic           clkz_out,
  output logic           zpos,
  output logic           zneg
);

  logic [2:0]     ph;
  logic [2:0]     ph_nxt;
  zx_pkg::turbo_t turbo_r;
  zx_pkg::turbo_t turbo_nxt;
  logic           clk_nxt;

  // counter bit that gives the selected division
  function automatic logic clk_bit(input logic [2:0] p, input zx_pkg::turbo_t t);
    logic b;
    case (t)
      zx_pkg::TURBO_3M5: b = p[2];
      zx_pkg::TURBO_7M:  b = p[1];
      default:           b = p[0];  // 14M and the spare code
    endcase
    return b;
  endfunction

  assign ph_nxt = ph + 3'd1;

  // new speed only from phase 0, where every bit is low
  assign turbo_nxt = (ph == 3'd7) ? turbo : turbo_r;
  assign clk_nxt   = clk_bit(ph_nxt, turbo_nxt);

  always_ff @(posedge fclk) begin
    if (core_rst) begin
      ph       <= 3'd0;
      turbo_r  <= zx_pkg::TURBO_3M5;
      clkz_out <= 1'b0;
    end else begin
      ph       <= ph_nxt;
      turbo_r  <= turbo_nxt;
      clkz_out <= clk_nxt;
    end
  end

  // one cycle ahead of the clkz_out edges
  assign zpos = ~clkz_out & clk_nxt;
  assign zneg = clkz_out & ~clk_nxt;

endmodule

// File: src/zsignals.sv
`timescale 1ns/1ps

module zsignals (
  input  logic fclk,
  input  logic core_rst,
  input  logic iorq_n,
  input  logic rd_n,
  input  logic wr_n,
  input  logic m1_n,
  output logic iord,
  output logic iowr,
  output logic iowr_s,
  output logic intack
);

  // {iorq, rd, wr, m1}, active high
  logic [3:0] sync1;
  logic [3:0] sync2;
  logic       iorq;
  logic       rd;
  logic       wr;
  logic       m1;
  logic       iowr_d;

  always_ff @(posedge fclk) begin
    if (core_rst) begin
      sync1 <= 4'b0000;
      sync2 <= 4'b0000;
    end else begin
      sync1 <= ~{iorq_n, rd_n, wr_n, m1_n};
      sync2 <= sync1;
    end
  end

  assign {iorq, rd, wr, m1} = sync2;

  always_ff @(posedge fclk) begin
    if (core_rst) begin
      iord   <= 1'b0;
      iowr   <= 1'b0;
      intack <= 1'b0;
      iowr_d <= 1'b0;
    end else begin
      iord   <= iorq & rd & ~m1;
      iowr   <= iorq & wr & ~m1;
      intack <= iorq & m1;   // int ack cycle
      iowr_d <= iowr;
    end
  end

  assign iowr_s = iowr & ~iowr_d;  // rising edge

endmodule

// File: src/zports.sv
`timescale 1ns/1ps

module zports (
  input  logic           fclk,
  input  logic           core_rst,
  input  logic [15:0]    a,
  input  logic [7:0]     din,
  input  logic           iord,
  input  logic           iowr_s,
  input  logic           intack,
  input  logic           tape_in,
  input  logic [7:0]     vect,
  output logic [7:0]     dout,
  output logic           dout_en,
  output zx_pkg::turbo_t turbo,
  output logic           frame_int_en,
  output logic [2:0]     border,
  output logic           beep
);

  zx_pkg::port_sel_t port_sel;
  logic [7:0]        sysconf;
  logic [7:0]        intmask;
  logic              beeper;
  logic [7:0]        fe_rd;

  // full 16-bit match first, #FE only looks at the low byte
  always_comb begin
    if (a == zx_pkg::SYSCONF_ADDR)
      port_sel = zx_pkg::PORT_SYSCONF;
    else if (a == zx_pkg::INTMASK_ADDR)
      port_sel = zx_pkg::PORT_INTMASK;
    else if (a[7:0] == zx_pkg::PORT_FE_LOW)
      port_sel = zx_pkg::PORT_FE;
    else
      port_sel = zx_pkg::PORT_NONE;
  end

  always_ff @(posedge fclk) begin
    if (core_rst) begin
      border  <= 3'd0;
      beeper  <= 1'b0;
      sysconf <= zx_pkg::SYSCONF_RESET;
      intmask <= zx_pkg::INTMASK_RESET;
    end else if (iowr_s) begin
      case (port_sel)
        zx_pkg::PORT_FE: begin
          border <= din[2:0];
          beeper <= din[zx_pkg::FE_BEEPER_BIT];
        end
        zx_pkg::PORT_SYSCONF: sysconf <= din;
        zx_pkg::PORT_INTMASK: intmask <= din;
        default: ;
      endcase
    end
  end

  // keyboard lines float high, only the tape bit is live
  always_comb begin
    fe_rd = 8'hFF;
    fe_rd[zx_pkg::FE_TAPE_BIT] = tape_in;
  end

  always_comb begin
    dout    = 8'hFF;
    dout_en = 1'b0;
    if (intack) begin
      dout    = vect;      // IM2 vector read
      dout_en = 1'b1;
    end else if (iord) begin
      case (port_sel)
        zx_pkg::PORT_FE: begin
          dout    = fe_rd;
          dout_en = 1'b1;
        end
        zx_pkg::PORT_SYSCONF: begin
          dout    = sysconf;
          dout_en = 1'b1;
        end
        zx_pkg::PORT_INTMASK: begin
          dout    = intmask;
          dout_en = 1'b1;
        end
        default: ;
      endcase
    end
  end

  assign turbo        = zx_pkg::turbo_t'(sysconf[1:0]);
  assign frame_int_en = intmask[0];

  // tape mixed into the beeper when enabled
  assign beep = beeper | (sysconf[zx_pkg::SYSCONF_TAPE_SOUND_BIT] & tape_in);

endmodule

// File: src/zint.sv
`timescale 1ns/1ps

module zint #(
  parameter int FRAME_TICKS = 71680,
  parameter int INT_LEN     = 32
) (
  input  logic       fclk,
  input  logic       core_rst,
  input  logic       frame_int_en,
  input  logic       intack,
  output logic       int_n,
  output logic [7:0] vect
);

  localparam int FW = $clog2(FRAME_TICKS);
  localparam int LW = $clog2(INT_LEN + 1);

  logic [FW-1:0]      frame_cnt;
  logic               frame_end;
  logic [LW-1:0]      len_cnt;
  zx_pkg::int_state_t state;

  assign frame_end = (frame_cnt == FW'(FRAME_TICKS - 1));

  always_ff @(posedge fclk) begin
    if (core_rst)
      frame_cnt <= '0;
    else if (frame_end)
      frame_cnt <= '0;
    else
      frame_cnt <= frame_cnt + 1'b1;
  end

  always_ff @(posedge fclk) begin
    if (core_rst) begin
      state   <= zx_pkg::INT_IDLE;
      len_cnt <= '0;
    end else begin
      case (state)
        zx_pkg::INT_IDLE: begin
          len_cnt <= '0;
          if (frame_end && frame_int_en)
            state <= zx_pkg::INT_ACTIVE;
        end
        default: begin
          len_cnt <= len_cnt + 1'b1;
          // ends on timeout or when the cpu takes it
          if (intack || len_cnt == LW'(INT_LEN - 1))
            state <= zx_pkg::INT_IDLE;
        end
      endcase
    end
  end

  assign int_n = (state != zx_pkg::INT_ACTIVE);
  assign vect  = zx_pkg::IM2_FRAME_VECT;  // single source, fixed vector

endmodule

// File: src/zx_core_top.sv
`timescale 1ns/1ps

module zx_core_top #(
  parameter int FRAME_TICKS = 71680,
  parameter int INT_LEN     = 32,
  parameter int RST_STRETCH = 8
) (
  input  logic        fclk,
  input  logic        rst,
  input  logic        iorq_n,
  input  logic        rd_n,
  input  logic        wr_n,
  input  logic        m1_n,
  input  logic [15:0] a,
  input  logic [7:0]  din,
  input  logic        tape_in,
  output logic        clkz_out,
  output logic        int_n,
  output logic [7:0]  dout,
  output logic        dout_en,
  output logic [2:0]  border,
  output logic        beep
);

  logic             core_rst;
  zx_pkg::turbo_t   turbo;
  logic             iord;
  logic             iowr_s;
  logic             intack;
  logic             frame_int_en;
  logic [7:0]       vect;

  resetter #(.RST_STRETCH(RST_STRETCH)) u_resetter (
    .fclk     (fclk),
    .rst      (rst),
    .core_rst (core_rst)
  );

  // zpos/zneg not needed by this core, left open
  zclock u_zclock (
    .fclk     (fclk),
    .core_rst (core_rst),
    .turbo    (turbo),
    .clkz_out (clkz_out),
    .zpos     (),
    .zneg     ()
  );

  zsignals u_zsignals (
    .fclk     (fclk),
    .core_rst (core_rst),
    .iorq_n   (iorq_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .m1_n     (m1_n),
    .iord     (iord),
    .iowr     (),
    .iowr_s   (iowr_s),
    .intack   (intack)
  );

  zports u_zports (
    .fclk         (fclk),
    .core_rst     (core_rst),
    .a            (a),
    .din          (din),
    .iord         (iord),
    .iowr_s       (iowr_s),
    .intack       (intack),
    .tape_in      (tape_in),
    .vect         (vect),
    .dout         (dout),
    .dout_en      (dout_en),
    .turbo        (turbo),
    .frame_int_en (frame_int_en),
    .border       (border),
    .beep         (beep)
  );

  zint #(
    .FRAME_TICKS (FRAME_TICKS),
    .INT_LEN     (INT_LEN)
  ) u_zint (
    .fclk         (fclk),
    .core_rst     (core_rst),
    .frame_int_en (frame_int_en),
    .intack       (intack),
    .int_n        (int_n),
    .vect         (vect)
  );

endmodule

// File: dv/tb_tasks.svh
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

int errors = 0;
int checks = 0;

task automatic compare_val(input string name, input logic [15:0] got, input logic [15:0] exp);
  checks++;
  assert (got === exp) else begin
    errors++;
    $display("Error at %0t ns: %s expected %0h, got %0h", $time, name, exp, got);
  end
endtask

task automatic confirm(input bit ok, input string what);
  checks++;
  assert (ok) else begin
    errors++;
    $display("At %0t ns: %s", $time, what);
  end
endtask

task automatic apply_reset();
  @(negedge fclk);
  rst = 1'b1;
  repeat (2) @(negedge fclk);
  rst = 1'b0;
endtask

// clkz_out stays low until the internal reset is over
task automatic wait_core_ready();
  int n;
  n = 0;
  while (!clkz_out && n < 40) begin
    @(negedge fclk);
    n++;
  end
  confirm(clkz_out, "clkz_out did not start toggling after reset");
endtask

task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
  @(negedge fclk);
  a   = addr;
  din = data;
  @(negedge fclk);
  iorq_n = 1'b0;
  wr_n   = 1'b0;
  repeat (8) @(negedge fclk);
  iorq_n = 1'b1;
  wr_n   = 1'b1;
  repeat (2) @(negedge fclk);  // a and din held past the strobes
endtask

// io read or int ack, dout taken while dout_en is high
task automatic read_strobe(input bit ack, output logic [7:0] data, output bit seen);
  int n;
  data = 8'h00;
  seen = 1'b0;
  @(negedge fclk);
  iorq_n = 1'b0;
  rd_n   = ack;
  m1_n   = !ack;
  repeat (8) begin
    @(negedge fclk);
    if (dout_en) begin
      seen = 1'b1;
      data = dout;
    end
  end
  iorq_n = 1'b1;
  rd_n   = 1'b1;
  m1_n   = 1'b1;
  n = 0;
  while (dout_en && n < 6) begin
    @(negedge fclk);
    n++;
  end
  confirm(!dout_en, "dout_en still high 6 cycles after the strobes were released");
endtask

task automatic io_read(input logic [15:0] addr, output logic [7:0] data, output bit seen);
  @(negedge fclk);
  a = addr;
  read_strobe(1'b0, data, seen);
endtask

task automatic int_ack(output logic [7:0] data, output bit seen);
  read_strobe(1'b1, data, seen);
endtask

// fclk cycles between two rising edges of clkz_out
task automatic measure_period(output int period);
  logic prev;
  int   n;
  int   rises;
  rises = 0;
  n = 0;
  @(negedge fclk);
  prev = clkz_out;
  while (rises < 2 && n < 40) begin  // second rise starts the count
    @(negedge fclk);
    n++;
    if (!prev && clkz_out)
      rises++;
    prev = clkz_out;
  end
  period = 0;
  while (period < 20) begin
    @(negedge fclk);
    period++;
    if (!prev && clkz_out)
      break;
    prev = clkz_out;
  end
  confirm(rises == 2 && period < 20, "clkz_out stopped while its period was measured");
endtask

`endif

// File: dv/tb_zx_core.sv
`timescale 1ns/1ps

module tb_zx_core;

  localparam int FRAME_TICKS = 2000;
  localparam int INT_LEN     = 32;
  localparam int RST_STRETCH = 8;

  logic        fclk;
  logic        rst;
  logic        iorq_n;
  logic        rd_n;
  logic        wr_n;
  logic        m1_n;
  logic [15:0] a;
  logic [7:0]  din;
  logic        tape_in;
  logic        clkz_out;
  logic        int_n;
  logic [7:0]  dout;
  logic        dout_en;
  logic [2:0]  border;
  logic        beep;
  int          seed = 99;

  zx_core_top #(
    .FRAME_TICKS (FRAME_TICKS),
    .INT_LEN     (INT_LEN),
    .RST_STRETCH (RST_STRETCH)
  ) UUT (
    .fclk     (fclk),
    .rst      (rst),
    .iorq_n   (iorq_n),
    .rd_n     (rd_n),
    .wr_n     (wr_n),
    .m1_n     (m1_n),
    .a        (a),
    .din      (din),
    .tape_in  (tape_in),
    .clkz_out (clkz_out),
    .int_n    (int_n),
    .dout     (dout),
    .dout_en  (dout_en),
    .border   (border),
    .beep     (beep)
  );

  `include "tb_tasks.svh"

  initial begin
    fclk = 1'b0;
    forever #5 fclk = ~fclk;
  end

  task automatic reset_defaults();
    logic [7:0] rd;
    bit         en;
    int         period;
    compare_val("int_n", int_n, 1'b1);
    compare_val("dout_en", dout_en, 1'b0);
    compare_val("border", border, 3'd0);
    compare_val("beep", beep, 1'b0);
    io_read(zx_pkg::SYSCONF_ADDR, rd, en);
    compare_val("dout_en", en, 1'b1);
    compare_val("sysconf", rd, 8'h00);
    io_read(zx_pkg::INTMASK_ADDR, rd, en);
    compare_val("intmask", rd, zx_pkg::INTMASK_RESET);
    measure_period(period);
    compare_val("clkz_out period", period, 8);
  endtask

  task automatic register_readback();
    logic [7:0] wdata;
    logic [7:0] rd;
    bit         en;
    repeat (3) begin
      wdata = 8'($random(seed));
      io_write(zx_pkg::SYSCONF_ADDR, wdata);
      io_read(zx_pkg::SYSCONF_ADDR, rd, en);
      compare_val("sysconf", rd, wdata);
      wdata = 8'($random(seed));
      io_write(zx_pkg::INTMASK_ADDR, wdata);
      io_read(zx_pkg::INTMASK_ADDR, rd, en);
      compare_val("intmask", rd, wdata);
    end
    io_write(zx_pkg::SYSCONF_ADDR, 8'h00);
    io_write(zx_pkg::INTMASK_ADDR, zx_pkg::INTMASK_RESET);
    tape_in = 1'b0;
    io_read(16'hFBFE, rd, en);
    compare_val("port FE", rd, 8'hBF);
    tape_in = 1'b1;
    io_read(16'h7FFE, rd, en);
    compare_val("port FE", rd, 8'hFF);
    tape_in = 1'b0;
    io_read(16'h00AF, rd, en);  // low byte of sysconf only
    confirm(!en, "dout_en went high on a read of unmapped port 00AF");
    io_read(16'h1234, rd, en);
    confirm(!en, "dout_en went high on a read of unmapped port 1234");
  endtask

  task automatic turbo_speeds();
    int exp_period[4] = '{8, 4, 2, 2};
    int period;
    for (int t = 0; t < 4; t++) begin
      io_write(zx_pkg::SYSCONF_ADDR, 8'(t));
      measure_period(period);
      compare_val("clkz_out period", period, exp_period[t]);
    end
    io_write(zx_pkg::SYSCONF_ADDR, 8'h00);
  endtask

  task automatic border_and_beeper();
    logic [7:0] wdata;
    repeat (2) begin
      wdata = 8'($random(seed));
      io_write(16'hFEFE, wdata);
      compare_val("border", border, wdata[2:0]);
      compare_val("beep", beep, wdata[zx_pkg::FE_BEEPER_BIT]);
    end
    wdata[zx_pkg::FE_BEEPER_BIT] = 1'b0;
    io_write(16'hFEFE, wdata);
    io_write(zx_pkg::SYSCONF_ADDR, 8'h01 << zx_pkg::SYSCONF_TAPE_SOUND_BIT);
    tape_in = 1'b1;
    @(negedge fclk);
    compare_val("beep", beep, 1'b1);  // mixed tape
    tape_in = 1'b0;
    @(negedge fclk);
    compare_val("beep", beep, 1'b0);
    io_write(zx_pkg::SYSCONF_ADDR, 8'h00);
    tape_in = 1'b1;
    @(negedge fclk);
    compare_val("beep", beep, 1'b0);
    tape_in = 1'b0;
  endtask

  task automatic frame_interrupt();
    logic [7:0] rd;
    bit         en;
    bit         low_seen;
    int         n;
    apply_reset();
    n = 0;
    // counted from rst release, so the stretch is added
    while (int_n && n < FRAME_TICKS + RST_STRETCH + 10) begin
      @(negedge fclk);
      n++;
    end
    confirm(!int_n, "int_n did not fall within one frame after reset");
    confirm(n >= FRAME_TICKS, "int_n fell before a full frame had passed");
    int_ack(rd, en);
    compare_val("dout_en", en, 1'b1);
    compare_val("vect", rd, zx_pkg::IM2_FRAME_VECT);
    compare_val("int_n", int_n, 1'b1);
    io_write(zx_pkg::INTMASK_ADDR, 8'h00);
    low_seen = 1'b0;
    for (n = 0; n < 2 * FRAME_TICKS; n++) begin
      @(negedge fclk);
      if (!int_n)
        low_seen = 1'b1;
    end
    confirm(!low_seen, "int_n fell while the frame interrupt was masked");
  endtask

  initial begin
    rst     = 1'b1;
    iorq_n  = 1'b1;
    rd_n    = 1'b1;
    wr_n    = 1'b1;
    m1_n    = 1'b1;
    a       = 16'h0000;
    din     = 8'h00;
    tape_in = 1'b0;
    apply_reset();
    wait_core_ready();
    reset_defaults();
    register_readback();
    turbo_speeds();
    border_and_beeper();
    frame_interrupt();
    $display("Checks run: %0d, failed: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+dv
src/zx_pkg.sv
src/resetter.sv
src/zclock.sv
src/zsignals.sv
src/zports.sv
src/zint.sv
src/zx_core_top.sv
dv/tb_zx_core.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_zx_core
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = No errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
